/* verilog/mshr_pkg.sv */
package mshr_pkg;

////////////////////////////////////////////////////////////////////////////
// sizes.
////////////////////////////////////////////////////////////////////////////

    localparam int mshr_depth = 8;
    localparam int paddr_w    = 15;
    localparam int line_lsb   = 4;
    localparam int qslot_w    = 8;
    localparam int data_w     = 32;
    localparam int ptr_w      = 3;

    // wake vector bit positions.
    localparam int wake_rd = 0;
    localparam int wake_wr = 1;

////////////////////////////////////////////////////////////////////////////
// request and queue entry.
////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [paddr_w-1:0] paddr;
        logic [qslot_w-1:0] slots;
        logic               is_write;
    } miss_req_t;

    typedef struct packed {
        logic               valid;
        logic [paddr_w-1:0] paddr;
        logic [qslot_w-1:0] slots;
        logic [1:0]         wake;
    } mshr_entry_t;

    // fill broadcast to the load/store queue.
    typedef struct packed {
        logic [paddr_w-1:0] paddr;
        logic [qslot_w-1:0] slots;
        logic [1:0]         wake;
        logic [data_w-1:0]  data;
        logic               err;
    } wake_t;

////////////////////////////////////////////////////////////////////////////
// apb.
////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
    } apb_req_t;

    typedef struct packed {
        logic [data_w-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

/* verilog/mshr_queue.sv */
`timescale 1ns/10ps

module mshr_queue (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             push,
    input  mshr_pkg::mshr_entry_t                            push_entry,
    input  logic                                             pop,
    input  logic [mshr_pkg::mshr_depth-1:0]                  modify_mask,
    input  mshr_pkg::mshr_entry_t [mshr_pkg::mshr_depth-1:0] modify_entries,
    output mshr_pkg::mshr_entry_t [mshr_pkg::mshr_depth-1:0] entries,
    output logic [mshr_pkg::ptr_w-1:0]                       head_idx,
    output logic                                             full,
    output logic                                             empty
);

    logic [mshr_pkg::ptr_w-1:0]      head_ptr;
    logic [mshr_pkg::ptr_w-1:0]      tail_ptr;
    logic [mshr_pkg::ptr_w:0]        count;
    logic [mshr_pkg::mshr_depth-1:0] head_sel;
    logic [mshr_pkg::mshr_depth-1:0] tail_sel;
    logic                            push_ok;
    logic                            pop_ok;

    assign full     = (count == (mshr_pkg::ptr_w + 1)'(mshr_pkg::mshr_depth));
    assign empty    = (count == '0);
    assign head_idx = head_ptr;

    // overflow and underflow are ignored.
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    always_comb begin
        head_sel = '0;
        tail_sel = '0;
        head_sel[head_ptr] = 1'b1;
        tail_sel[tail_ptr] = 1'b1;
    end

////////////////////////////////////////////////////////////////////////////
// pointers and occupancy.
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push_ok) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (pop_ok) begin
                head_ptr <= head_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

////////////////////////////////////////////////////////////////////////////
// entry storage.
////////////////////////////////////////////////////////////////////////////

    // push and pop own their slot; other slots take the merge rewrite.
    for (genvar g = 0; g < mshr_pkg::mshr_depth; g++) begin : g_entry
        always_ff @(posedge clk) begin
            if (rst) begin
                entries[g].valid <= 1'b0;
            end else if (push_ok && tail_sel[g]) begin
                entries[g] <= push_entry;
            end else if (pop_ok && head_sel[g]) begin
                entries[g].valid <= 1'b0;
            end else if (modify_mask[g]) begin
                entries[g] <= modify_entries[g];
            end
        end
    end

endmodule

/* verilog/mshr.sv */
`timescale 1ns/10ps

module mshr (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid,
    input  mshr_pkg::miss_req_t          req,
    output logic                         req_ready,
    output logic                         req_hit,
    input  logic                         done,
    output mshr_pkg::mshr_entry_t        head,
    output logic                         head_valid,
    output logic [mshr_pkg::qslot_w-1:0] merge_slots,
    output logic [1:0]                   merge_wake
);

    mshr_pkg::mshr_entry_t [mshr_pkg::mshr_depth-1:0] entries;
    mshr_pkg::mshr_entry_t [mshr_pkg::mshr_depth-1:0] modify_entries;
    mshr_pkg::mshr_entry_t                            push_entry;
    logic [mshr_pkg::mshr_depth-1:0]                  hit_vec;
    logic [mshr_pkg::mshr_depth-1:0]                  modify_mask;
    logic [mshr_pkg::ptr_w-1:0]                       head_idx;
    logic [1:0]                                       req_wake;
    logic                                             full;
    logic                                             empty;
    logic                                             accept;
    logic                                             take_hit;
    logic                                             take_miss;

    // a write wakes the store side, anything else the load side.
    always_comb begin
        req_wake = '0;
        if (req.is_write) begin
            req_wake[mshr_pkg::wake_wr] = 1'b1;
        end else begin
            req_wake[mshr_pkg::wake_rd] = 1'b1;
        end
    end

////////////////////////////////////////////////////////////////////////////
// line address match.
////////////////////////////////////////////////////////////////////////////

    // at most one entry can match since hits never allocate.
    always_comb begin
        for (int i = 0; i < mshr_pkg::mshr_depth; i++) begin
            hit_vec[i] = entries[i].valid &&
                (entries[i].paddr[mshr_pkg::paddr_w-1:mshr_pkg::line_lsb] ==
                 req.paddr[mshr_pkg::paddr_w-1:mshr_pkg::line_lsb]);
        end
    end

    assign req_hit   = req_valid && (|hit_vec);
    assign req_ready = req_hit || !full;
    assign accept    = req_valid && req_ready;
    assign take_hit  = accept && req_hit;
    assign take_miss = accept && !req_hit;

////////////////////////////////////////////////////////////////////////////
// merge and allocate.
////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < mshr_pkg::mshr_depth; i++) begin
            modify_entries[i]       = entries[i];
            modify_entries[i].slots = entries[i].slots | req.slots;
            modify_entries[i].wake  = entries[i].wake | req_wake;
        end
    end

    assign modify_mask = take_hit ? hit_vec : '0;

    assign push_entry = '{
        valid: 1'b1,
        paddr: req.paddr,
        slots: req.slots,
        wake:  req_wake
    };

    mshr_queue u_queue (
        .clk            (clk),
        .rst            (rst),
        .push           (take_miss),
        .push_entry     (push_entry),
        .pop            (done),
        .modify_mask    (modify_mask),
        .modify_entries (modify_entries),
        .entries        (entries),
        .head_idx       (head_idx),
        .full           (full),
        .empty          (empty)
    );

    assign head       = entries[head_idx];
    assign head_valid = !empty;

    // a merge into the head in the completion cycle would be lost on pop.
    always_comb begin
        merge_slots = '0;
        merge_wake  = '0;
        if (take_hit && hit_vec[head_idx]) begin
            merge_slots = req.slots;
            merge_wake  = req_wake;
        end
    end

endmodule

/* verilog/fill_apb_master.sv */
`timescale 1ns/10ps

module fill_apb_master (
    input  logic                         clk,
    input  logic                         rst,
    input  mshr_pkg::mshr_entry_t        head,
    input  logic                         head_valid,
    input  logic [mshr_pkg::qslot_w-1:0] merge_slots,
    input  logic [1:0]                   merge_wake,
    output mshr_pkg::apb_req_t           apb_req,
    input  mshr_pkg::apb_rsp_t           apb_rsp,
    output logic                         done,
    output logic                         wake_valid,
    output mshr_pkg::wake_t              wake
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } state_t;

    state_t      state;
    logic [31:0] paddr_q;

    // completion is the access phase with pready.
    assign done = (state == st_access) && apb_rsp.pready;

////////////////////////////////////////////////////////////////////////////
// apb read sequence.
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            wake_valid <= 1'b0;
        end else begin
            wake_valid <= done;
            case (state)
                st_idle: begin
                    if (head_valid) begin
                        state <= st_setup;
                    end
                end
                st_setup: state <= st_access;
                st_access: begin
                    if (apb_rsp.pready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // line aligned address, held for the whole transfer.
    always_ff @(posedge clk) begin
        if (state == st_idle && head_valid) begin
            paddr_q <= 32'({head.paddr[mshr_pkg::paddr_w-1:mshr_pkg::line_lsb],
                            {mshr_pkg::line_lsb{1'b0}}});
        end
    end

    always_comb begin
        apb_req.psel    = (state != st_idle);
        apb_req.penable = (state == st_access);
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = paddr_q;
    end

////////////////////////////////////////////////////////////////////////////
// wake broadcast.
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (done) begin
            wake.paddr <= head.paddr;
            wake.slots <= head.slots | merge_slots;
            wake.wake  <= head.wake | merge_wake;
            wake.data  <= apb_rsp.prdata;
            wake.err   <= apb_rsp.pslverr;
        end
    end

endmodule

/* verilog/miss_handler_top.sv */
`timescale 1ns/10ps

module miss_handler_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  mshr_pkg::miss_req_t req,
    output logic               req_ready,
    output logic               req_hit,
    output mshr_pkg::apb_req_t apb_req,
    input  mshr_pkg::apb_rsp_t apb_rsp,
    output logic               wake_valid,
    output mshr_pkg::wake_t    wake
);

    mshr_pkg::mshr_entry_t        head;
    logic                         head_valid;
    logic                         done;
    logic [mshr_pkg::qslot_w-1:0] merge_slots;
    logic [1:0]                   merge_wake;

    // miss tracking.
    mshr u_mshr (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .req_hit     (req_hit),
        .done        (done),
        .head        (head),
        .head_valid  (head_valid),
        .merge_slots (merge_slots),
        .merge_wake  (merge_wake)
    );

    // line fill over apb, oldest entry first.
    fill_apb_master u_fill (
        .clk         (clk),
        .rst         (rst),
        .head        (head),
        .head_valid  (head_valid),
        .merge_slots (merge_slots),
        .merge_wake  (merge_wake),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .done        (done),
        .wake_valid  (wake_valid),
        .wake        (wake)
    );

endmodule

/* tests/miss_handler_properties.sv */
`timescale 1ns/10ps

module miss_handler_properties (
    input logic               clk,
    input logic               rst,
    input mshr_pkg::apb_req_t apb_req,
    input mshr_pkg::apb_rsp_t apb_rsp,
    input logic               wake_valid,
    input logic               req_hit,
    input logic               req_ready
);

    // setup phase leads straight into the access phase.
    assert property (@(posedge clk) disable iff (rst)
        apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable)
        else $error("penable did not follow psel");

    // address and direction hold until pready completes the access.
    assert property (@(posedge clk) disable iff (rst)
        apb_req.psel && !(apb_req.penable && apb_rsp.pready)
        |=> apb_req.psel && !apb_req.pwrite && $stable(apb_req.paddr))
        else $error("apb request changed before completion");

    assert property (@(posedge clk) disable iff (rst)
        wake_valid |=> !wake_valid)
        else $error("wake_valid lasted more than one cycle");

    assert property (@(posedge clk) disable iff (rst)
        req_hit |-> req_ready)
        else $error("req_ready low on a hit");

endmodule

// apb side on the fill master, request side on the mshr.
bind fill_apb_master miss_handler_properties u_fill_props (
    .clk        (clk),
    .rst        (rst),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .wake_valid (wake_valid),
    .req_hit    (1'b0),
    .req_ready  (1'b1)
);

bind mshr miss_handler_properties u_mshr_props (
    .clk        (clk),
    .rst        (rst),
    .apb_req    ('0),
    .apb_rsp    ('0),
    .wake_valid (1'b0),
    .req_hit    (req_hit),
    .req_ready  (req_ready)
);

/* tests/miss_handler_tb.sv */
`timescale 1ns/10ps

module miss_handler_tb;

    localparam int          clk_period = 100;
    localparam logic [31:0] data_key   = 32'h5a5a_0000;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    mshr_pkg::miss_req_t   req;
    logic                  req_ready;
    logic                  req_hit;
    mshr_pkg::apb_req_t    apb_req;
    mshr_pkg::apb_rsp_t    apb_rsp;
    logic                  wake_valid;
    mshr_pkg::wake_t       wake;

    // reference model, oldest entry first.
    mshr_pkg::mshr_entry_t model_q[$];
    mshr_pkg::wake_t       exp_wake;
    logic                  exp_wake_valid;
    logic                  stall;
    int                    wait_cnt;
    int                    cycle_cnt;
    int                    cycle_limit;

    miss_handler_top dut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .req_hit    (req_hit),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .wake_valid (wake_valid),
        .wake       (wake)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

////////////////////////////////////////////////////////////////////////////
// line address helpers and compare tasks.
////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] line_addr(input logic [mshr_pkg::paddr_w-1:0] paddr);
        return 32'(paddr >> mshr_pkg::line_lsb) << mshr_pkg::line_lsb;
    endfunction

    function automatic logic same_line(input logic [mshr_pkg::paddr_w-1:0] a,
                                       input logic [mshr_pkg::paddr_w-1:0] b);
        return (a >> mshr_pkg::line_lsb) == (b >> mshr_pkg::line_lsb);
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic compare_wake(input mshr_pkg::wake_t got, input mshr_pkg::wake_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: wake %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic compare_apb(input mshr_pkg::apb_req_t got, input mshr_pkg::apb_req_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: apb_req %h, expected %h", $time, got, exp));
        end
    endtask

////////////////////////////////////////////////////////////////////////////
// one clock cycle, falling edge to falling edge.
////////////////////////////////////////////////////////////////////////////

    task automatic step(input logic valid, input mshr_pkg::miss_req_t r, input logic exp_hit);
        int                    hit_idx;
        logic                  model_ready;
        mshr_pkg::apb_req_t    exp_apb;
        mshr_pkg::mshr_entry_t new_entry;
        @(negedge clk);
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            stop_run("timeout: the fills did not finish within the cycle limit");
        end
        compare_bit("wake_valid", wake_valid, exp_wake_valid);
        if (exp_wake_valid) begin
            compare_wake(wake, exp_wake);
        end
        exp_wake_valid = 1'b0;
        // memory model, one setup check per transfer.
        apb_rsp.pready = 1'b0;
        apb_rsp.prdata = apb_req.paddr ^ data_key;
        if (apb_req.psel && !apb_req.penable) begin
            if (model_q.size() == 0) begin
                stop_run("APB read started with no outstanding miss");
            end else begin
                exp_apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0,
                            paddr: line_addr(model_q[0].paddr)};
                compare_apb(apb_req, exp_apb);
                wait_cnt = $urandom % 4;
            end
        end else if (apb_req.psel && apb_req.penable && !stall) begin
            if (wait_cnt == 0) begin
                apb_rsp.pready = 1'b1;
            end else begin
                wait_cnt--;
            end
        end
        req_valid = valid;
        req       = r;
        #1;
        if (valid) begin
            hit_idx = -1;
            foreach (model_q[i]) begin
                if (same_line(model_q[i].paddr, r.paddr)) begin
                    hit_idx = i;
                end
            end
            model_ready = (hit_idx >= 0) || (model_q.size() < mshr_pkg::mshr_depth);
            if ((hit_idx >= 0) != exp_hit) begin
                stop_run("hit flag in the input file disagrees with the reference model");
            end
            compare_bit("req_hit", req_hit, exp_hit);
            compare_bit("req_ready", req_ready, model_ready);
            if (hit_idx >= 0) begin
                model_q[hit_idx].slots |= r.slots;
                model_q[hit_idx].wake[r.is_write] = 1'b1;
            end else if (model_ready) begin
                new_entry = '{valid: 1'b1, paddr: r.paddr, slots: r.slots,
                              wake: r.is_write ? 2'b10 : 2'b01};
                model_q.push_back(new_entry);
            end
        end
        // merges of this cycle are already folded in before the pop.
        if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
            exp_wake = '{paddr: model_q[0].paddr, slots: model_q[0].slots,
                         wake: model_q[0].wake, data: line_addr(model_q[0].paddr) ^ data_key,
                         err: 1'b0};
            exp_wake_valid = 1'b1;
            model_q.delete(0);
        end
    endtask

////////////////////////////////////////////////////////////////////////////
// stimulus from the input file.
////////////////////////////////////////////////////////////////////////////

    initial begin
        int                  fd;
        int                  n_cycles;
        int                  wr_flag;
        int                  hit_flag;
        logic [31:0]         addr_val;
        logic [31:0]         slot_val;
        string               line;
        string               cmd;
        string               lines[$];
        mshr_pkg::miss_req_t r;

        void'($urandom(32'h382c_6d4c));
        rst            = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        apb_rsp        = '0;
        stall          = 1'b0;
        exp_wake       = '0;
        exp_wake_valid = 1'b0;
        wait_cnt       = 0;
        cycle_cnt      = 0;
        cycle_limit    = 100;

        fd = $fopen("tests/miss_handler_input.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open tests/miss_handler_input.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                lines.push_back(line);
            end
            $fclose(fd);
        end
        cycle_limit = 40 * lines.size() + 100;

        // fill port stays quiet throughout reset.
        repeat (4) begin
            @(negedge clk);
            compare_bit("psel during reset", apb_req.psel, 1'b0);
            compare_bit("penable during reset", apb_req.penable, 1'b0);
            compare_bit("wake_valid during reset", wake_valid, 1'b0);
        end
        rst = 1'b0;

        foreach (lines[i]) begin
            cmd = "";
            void'($sscanf(lines[i], "%s", cmd));
            if (cmd == "req") begin
                void'($sscanf(lines[i], "%s %h %h %d %d", cmd, addr_val, slot_val,
                              wr_flag, hit_flag));
                r.paddr    = addr_val[mshr_pkg::paddr_w-1:0];
                r.slots    = slot_val[mshr_pkg::qslot_w-1:0];
                r.is_write = wr_flag[0];
                step(1'b1, r, hit_flag[0]);
            end else if (cmd == "idle") begin
                void'($sscanf(lines[i], "%s %d", cmd, n_cycles));
                repeat (n_cycles) step(1'b0, '0, 1'b0);
            end else if (cmd == "stall") begin
                stall = 1'b1;
            end else if (cmd == "release") begin
                stall = 1'b0;
            end else if (cmd != "" && cmd != "#") begin
                stop_run({"unknown command in the input file: ", cmd});
            end
        end

        // let the remaining fills and their broadcasts drain.
        while (model_q.size() != 0 || exp_wake_valid) begin
            step(1'b0, '0, 1'b0);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

/* tests/miss_handler_input.txt */
# req columns: paddr (hex), slots (hex), is_write, expected hit
# other commands: stall, release, idle <cycles>
req 0123 01 0 0
idle 12
stall
req 0450 02 0 0
req 0458 04 1 1
req 045f 08 0 1
release
idle 12
req 1000 10 0 0
req 2010 20 1 0
req 3020 40 0 0
idle 30
stall
req 4000 01 0 0
req 4010 02 1 0
req 4020 04 0 0
req 4030 08 1 0
req 4040 10 0 0
req 4050 20 1 0
req 4060 40 0 0
req 4070 80 1 0
req 5000 01 0 0
req 4035 01 1 1
release
idle 60

/* sources.f */
verilog/mshr_pkg.sv
verilog/mshr_queue.sv
verilog/mshr.sv
verilog/fill_apb_master.sv
verilog/miss_handler_top.sv
tests/miss_handler_properties.sv
tests/miss_handler_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the miss handler testbench with verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module miss_handler_tb -o miss_handler_sim -f sources.f

out=$(./obj_dir/miss_handler_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qF "All tests passed!"; then
    exit 0
else
    exit 1
fi
